// File: rtl/cfg_pkg.sv
package cfg_pkg;

  // Number of client engines sharing the stack engine
  localparam int ENGS_N  = 4;

  // Width of one stack data word
  localparam int DAT_W   = 32;

  // Number of nodes in the shared node memory, kept a power of two
  localparam int PTR_N   = 8;

  // Derived index widths
  localparam int ENGID_W = $clog2(ENGS_N);
  localparam int PTR_W   = $clog2(PTR_N);

endpackage : cfg_pkg

// File: rtl/stk_al_if.sv
interface stk_al_if import stk_pkg::*; ();

  // Allocation request from admission for a granted PUSH
  logic alloc_req;

  // Free list state, both combinational and including the release bypass
  logic empty;
  ptr_t ptr;

  // Node released by a successful POP in lookup
  logic dealloc_vld;
  ptr_t dealloc_ptr;

  modport ad (output alloc_req, input empty);

  modport al (input alloc_req, dealloc_vld, dealloc_ptr, output empty, ptr);

  modport lk (output dealloc_vld, dealloc_ptr);

endinterface : stk_al_if

// File: rtl/stk_lk_if.sv
interface stk_lk_if import stk_pkg::*; ();

  // Granted command for the current cycle
  logic    vld;
  engid_t  engid;
  opcode_t opcode;
  dat_t    dat;

  // FULL when a PUSH found no free node, OK otherwise
  status_t status;

  // Node handed out by the allocator for a granted PUSH
  ptr_t    ptr;

  // Admission drives the command fields
  modport ad (output vld, engid, opcode, dat, status);

  // Lookup samples the whole command together with the node
  modport lk (input vld, engid, opcode, dat, status, ptr);

  // The allocator supplies the node pointer
  modport al (output ptr);

endinterface : stk_lk_if

// File: rtl/stk_pipe.sv
module stk_pipe import cfg_pkg::*, stk_pkg::*; (
  // Client command ports, one lane per engine
    input  wire opcode_t [ENGS_N-1:0] i_cmd_opcode
  , input  wire dat_t    [ENGS_N-1:0] i_cmd_dat
  , output wire logic    [ENGS_N-1:0] o_cmd_ack

  // Response port shared by all engines
  , output wire logic                 o_rsp_vld
  , output wire engid_t               o_rsp_engid
  , output wire opcode_t              o_rsp_opcode
  , output wire status_t              o_rsp_status
  , output wire dat_t                 o_rsp_dat

  , input  wire logic                 clk
  , input  wire logic                 i_arst_n
);

  // Granted command, AD to LK
  stk_lk_if lk_if ();

  // Free list traffic between AD, LK and AL
  stk_al_if al_if ();

  // Admission picks one engine per cycle
  stk_pipe_ad u_stk_pipe_ad (
      .i_cmd_opcode (i_cmd_opcode)
    , .i_cmd_dat    (i_cmd_dat)
    , .o_cmd_ack    (o_cmd_ack)
    , .lk           (lk_if.ad)
    , .al           (al_if.ad)
    , .clk          (clk)
    , .i_arst_n     (i_arst_n)
  );

  // The allocated node joins the granted command on its way to LK
  stk_pipe_al u_stk_pipe_al (
      .al           (al_if.al)
    , .o_lk_ptr     (lk_if.ptr)
    , .clk          (clk)
    , .i_arst_n     (i_arst_n)
  );

  // Lookup executes the command and answers
  stk_pipe_lk u_stk_pipe_lk (
      .lk           (lk_if.lk)
    , .al           (al_if.lk)
    , .o_rsp_vld    (o_rsp_vld)
    , .o_rsp_engid  (o_rsp_engid)
    , .o_rsp_opcode (o_rsp_opcode)
    , .o_rsp_status (o_rsp_status)
    , .o_rsp_dat    (o_rsp_dat)
    , .clk          (clk)
    , .i_arst_n     (i_arst_n)
  );

endmodule : stk_pipe

// File: rtl/stk_pipe_ad.sv
module stk_pipe_ad import cfg_pkg::*, stk_pkg::*; (
  // Per engine command inputs, held until acknowledged
    input  wire opcode_t [ENGS_N-1:0] i_cmd_opcode
  , input  wire dat_t    [ENGS_N-1:0] i_cmd_dat
  , output wire logic    [ENGS_N-1:0] o_cmd_ack

  // Granted command towards lookup
  , stk_lk_if.ad                      lk

  // Allocation handshake with the free list
  , stk_al_if.ad                      al

  , input  wire logic                 clk
  , input  wire logic                 i_arst_n
);

  // Engines with a command other than NOP
  logic [ENGS_N-1:0] req;

  // Engine that has the highest priority this cycle
  engid_t            rr_q;

  // Winner of this cycle's arbitration
  engid_t            win;
  logic              win_vld;
  opcode_t           win_opcode;
  logic [ENGS_N-1:0] ack;

  // A free list that is empty even after the bypass means no node for a PUSH
  logic              win_push;

  always_comb begin
    for (int e = 0; e < ENGS_N; e++) begin
      req[e] = (i_cmd_opcode[e] != NOP);
    end
  end

  // Scan the engines starting at the priority pointer
  // The index wraps naturally because ENGS_N is a power of two
  always_comb begin
    engid_t idx;
    win_vld = 1'b0;
    win     = rr_q;
    for (int i = 0; i < ENGS_N; i++) begin
      idx = rr_q + engid_t'(i);
      if (!win_vld && req[idx]) begin
        win_vld = 1'b1;
        win     = idx;
      end
    end
  end

  // One-hot ack for the winner, zero when nobody asks
  always_comb begin
    ack = '0;
    if (win_vld) begin
      ack[win] = 1'b1;
    end
  end

  assign o_cmd_ack  = ack;
  assign win_opcode = i_cmd_opcode[win];
  assign win_push   = win_vld && (win_opcode == PUSH);

  // The granted command goes straight to the lookup register
  assign lk.vld    = win_vld;
  assign lk.engid  = win;
  assign lk.opcode = win_opcode;
  assign lk.dat    = i_cmd_dat[win];
  assign lk.status = (win_push && al.empty) ? FULL : OK;

  // Only a PUSH that can get a node takes one from the free list
  assign al.alloc_req = win_push && !al.empty;

  // After a grant the engine behind the winner gets first chance
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rr_q <= '0;
    end else if (win_vld) begin
      rr_q <= win + engid_t'(1);
    end
  end

endmodule : stk_pipe_ad

// File: rtl/stk_pipe_al.sv
module stk_pipe_al import cfg_pkg::*, stk_pkg::*; (
  // Allocation and release traffic
    stk_al_if.al          al

  // Allocated node, carried to lookup with the command
  , output wire ptr_t     o_lk_ptr

  , input  wire logic     clk
  , input  wire logic     i_arst_n
);

  // Circular FIFO of free node pointers
  ptr_t           fifo_q [PTR_N];
  ptr_t           rd_q;
  ptr_t           wr_q;
  logic [PTR_W:0] cnt_q;

  logic           fifo_empty;
  logic           use_bypass;
  logic           do_pop;
  logic           do_push;
  ptr_t           alloc_ptr;

  assign fifo_empty = (cnt_q == '0);

  // With no stored node, the node being released this cycle is handed out
  assign alloc_ptr = fifo_empty ? al.dealloc_ptr : fifo_q[rd_q];
  assign al.empty  = fifo_empty && !al.dealloc_vld;
  assign al.ptr    = alloc_ptr;
  assign o_lk_ptr  = alloc_ptr;

  // A bypassed node goes directly from release to allocation
  assign use_bypass = al.alloc_req && fifo_empty && al.dealloc_vld;
  assign do_pop     = al.alloc_req && !fifo_empty;
  assign do_push    = al.dealloc_vld && !use_bypass;

  // At reset every node is free, stored in index order
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_q  <= '0;
      wr_q  <= '0;
      cnt_q <= (PTR_W + 1)'(PTR_N);
      for (int i = 0; i < PTR_N; i++) begin
        fifo_q[i] <= ptr_t'(i);
      end
    end else begin
      if (do_push) begin
        fifo_q[wr_q] <= al.dealloc_ptr;
        wr_q         <= wr_q + ptr_t'(1);
      end
      if (do_pop) begin
        rd_q <= rd_q + ptr_t'(1);
      end
      // Count is unchanged when a pop and a push meet in one cycle
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + (PTR_W + 1)'(1);
        2'b01:   cnt_q <= cnt_q - (PTR_W + 1)'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule : stk_pipe_al

// File: rtl/stk_pipe_lk.sv
module stk_pipe_lk import cfg_pkg::*, stk_pkg::*; (
  // Granted command from admission
    stk_lk_if.lk          lk

  // Node release towards the free list
  , stk_al_if.lk          al

  // Registered response
  , output wire logic     o_rsp_vld
  , output wire engid_t   o_rsp_engid
  , output wire opcode_t  o_rsp_opcode
  , output wire status_t  o_rsp_status
  , output wire dat_t     o_rsp_dat

  , input  wire logic     clk
  , input  wire logic     i_arst_n
);

  // Command register between admission and execution
  logic              cmd_vld_q;
  engid_t            cmd_engid_q;
  opcode_t           cmd_opcode_q;
  status_t           cmd_status_q;
  ptr_t              cmd_ptr_q;
  dat_t              cmd_dat_q;
  logic              cmd_dat_en;

  // Head of each engine's stack
  ptr_t              head_q [ENGS_N];
  logic [ENGS_N-1:0] head_vld_q;

  // Node memory, each node holds a word and a link to the node below
  dat_t              node_dat_q [PTR_N];
  ptr_t              node_nxt_q [PTR_N];
  logic [PTR_N-1:0]  node_nxt_vld_q;

  // Execution of the registered command
  ptr_t              cur_head;
  logic              cur_vld;
  logic              push_ok;
  logic              pop_ok;
  status_t           rsp_status;
  dat_t              rsp_dat;

  // Response register
  logic              rsp_vld_q;
  engid_t            rsp_engid_q;
  opcode_t           rsp_opcode_q;
  status_t           rsp_status_q;
  dat_t              rsp_dat_q;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cmd_vld_q <= 1'b0;
    end else begin
      cmd_vld_q <= lk.vld;
    end
  end

  always_ff @(posedge clk) begin
    if (lk.vld) begin
      cmd_engid_q  <= lk.engid;
      cmd_opcode_q <= lk.opcode;
      cmd_status_q <= lk.status;
      cmd_ptr_q    <= lk.ptr;
    end
  end

  // Only a PUSH carries a word worth keeping
  assign cmd_dat_en = lk.vld && (lk.opcode == PUSH);

  always_ff @(posedge clk) begin
    if (cmd_dat_en) begin
      cmd_dat_q <= lk.dat;
    end
  end

  assign cur_head = head_q[cmd_engid_q];
  assign cur_vld  = head_vld_q[cmd_engid_q];

  // A FULL push changes nothing, a POP on an empty stack frees nothing
  assign push_ok = cmd_vld_q && (cmd_opcode_q == PUSH) && (cmd_status_q == OK);
  assign pop_ok  = cmd_vld_q && (cmd_opcode_q == POP) && cur_vld;

  // The popped head goes back to the free list in this same cycle
  assign al.dealloc_vld = pop_ok;
  assign al.dealloc_ptr = cur_head;

  // A successful PUSH echoes its word, POP and PEEK return the top word
  always_comb begin
    rsp_status = cmd_status_q;
    rsp_dat    = '0;
    case (cmd_opcode_q)
      PUSH: begin
        if (cmd_status_q == OK) begin
          rsp_dat = cmd_dat_q;
        end
      end
      POP, PEEK: begin
        if (cur_vld) begin
          rsp_dat = node_dat_q[cur_head];
        end else begin
          rsp_status = EMPTY;
        end
      end
      default: begin
        rsp_dat = '0;
      end
    endcase
  end

  // New node is linked above the current head
  always_ff @(posedge clk) begin
    if (push_ok) begin
      node_dat_q[cmd_ptr_q]     <= cmd_dat_q;
      node_nxt_q[cmd_ptr_q]     <= cur_head;
      node_nxt_vld_q[cmd_ptr_q] <= cur_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      head_q[cmd_engid_q] <= cmd_ptr_q;
    end else if (pop_ok) begin
      head_q[cmd_engid_q] <= node_nxt_q[cur_head];
    end
  end

  // Popping the bottom node leaves the stack empty
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      head_vld_q <= '0;
    end else if (push_ok) begin
      head_vld_q[cmd_engid_q] <= 1'b1;
    end else if (pop_ok) begin
      head_vld_q[cmd_engid_q] <= node_nxt_vld_q[cur_head];
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= cmd_vld_q;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_vld_q) begin
      rsp_engid_q  <= cmd_engid_q;
      rsp_opcode_q <= cmd_opcode_q;
      rsp_status_q <= rsp_status;
      rsp_dat_q    <= rsp_dat;
    end
  end

  assign o_rsp_vld    = rsp_vld_q;
  assign o_rsp_engid  = rsp_engid_q;
  assign o_rsp_opcode = rsp_opcode_q;
  assign o_rsp_status = rsp_status_q;
  assign o_rsp_dat    = rsp_dat_q;

endmodule : stk_pipe_lk

// File: rtl/stk_pkg.sv
package stk_pkg;

  import cfg_pkg::*;

  // Command presented by each engine every cycle
  // NOP means the engine makes no request
  typedef enum logic [1:0] {
    NOP  = 2'd0,
    PUSH = 2'd1,
    POP  = 2'd2,
    PEEK = 2'd3
  } opcode_t;

  // Outcome reported with every response
  // FULL comes from admission, EMPTY from lookup
  typedef enum logic [1:0] {
    OK    = 2'd0,
    EMPTY = 2'd1,
    FULL  = 2'd2
  } status_t;

  // Index of a client engine
  typedef logic [ENGID_W-1:0] engid_t;

  // Index of a node in the shared node memory
  typedef logic [PTR_W-1:0]   ptr_t;

  // One stack data word
  typedef logic [DAT_W-1:0]   dat_t;

endpackage : stk_pkg

// File: run.sh
#!/bin/sh
# Build the stack engine testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_stk_pipe -f src.f -o sim_stk_pipe \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_stk_pipe > sim.log 2>&1
cat sim.log

grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed"; exit 1; } || exit 0

// File: src.f
rtl/cfg_pkg.sv
rtl/stk_pkg.sv
rtl/stk_lk_if.sv
rtl/stk_al_if.sv
rtl/stk_pipe_ad.sv
rtl/stk_pipe_al.sv
rtl/stk_pipe_lk.sv
rtl/stk_pipe.sv
verif/stk_pipe_checker.sv
verif/stk_pipe_asserts.sv
verif/tb_stk_pipe.sv

// File: verif/stk_pipe_asserts.sv
module stk_pipe_asserts import cfg_pkg::*, stk_pkg::*; (
    input  wire logic                 clk
  , input  wire logic                 i_arst_n
  , input  wire opcode_t [ENGS_N-1:0] i_cmd_opcode
  , input  wire logic    [ENGS_N-1:0] i_cmd_ack
  , input  wire logic                 i_rsp_vld
);

  timeunit 1ns;
  timeprecision 100ps;

  // Engines that present a real command
  logic [ENGS_N-1:0] req;

  // Number of assertions that have failed so far
  int                fail_n = 0;

  always_comb begin
    for (int e = 0; e < ENGS_N; e++) begin
      req[e] = (i_cmd_opcode[e] != NOP);
    end
  end

  // At most one engine is acked per cycle
  ack_onehot: assert property (@(posedge clk) disable iff (!i_arst_n) $onehot0(i_cmd_ack))
    else begin
      fail_n++;
      $error("More than one ack in one cycle");
    end

  // Only requesting engines can be acked
  ack_req: assert property (@(posedge clk) disable iff (!i_arst_n) (i_cmd_ack & ~req) == '0)
    else begin
      fail_n++;
      $error("Ack given to an engine with a NOP");
    end

  // The pipe has a fixed depth of two
  ack_rsp: assert property (@(posedge clk) disable iff (!i_arst_n) |i_cmd_ack |-> ##2 i_rsp_vld)
    else begin
      fail_n++;
      $error("Ack not followed by a response two cycles later");
    end

  // No response may appear while reset is held
  rst_quiet: assert property (@(posedge clk) !i_arst_n |-> !i_rsp_vld)
    else begin
      fail_n++;
      $error("Response valid during reset");
    end

endmodule : stk_pipe_asserts

bind stk_pipe stk_pipe_asserts u_stk_pipe_asserts (
    .clk          (clk)
  , .i_arst_n     (i_arst_n)
  , .i_cmd_opcode (i_cmd_opcode)
  , .i_cmd_ack    (o_cmd_ack)
  , .i_rsp_vld    (o_rsp_vld)
);

// File: verif/stk_pipe_checker.sv
module stk_pipe_checker import cfg_pkg::*, stk_pkg::*; (
    input  wire logic                       clk
  , input  wire logic                       i_arst_n
  , input  wire opcode_t [ENGS_N-1:0]       i_cmd_opcode
  , input  wire dat_t    [ENGS_N-1:0]       i_cmd_dat
  , input  wire logic    [ENGS_N-1:0]       i_cmd_ack
  , input  wire logic    [ENGS_N-1:0][15:0] i_cmd_row
  , input  wire logic                       i_rsp_vld
  , input  wire engid_t                     i_rsp_engid
  , input  wire opcode_t                    i_rsp_opcode
  , input  wire status_t                    i_rsp_status
  , input  wire dat_t                       i_rsp_dat
);

  timeunit 1ns;
  timeprecision 100ps;

  // Test name of every table row, filled by the testbench before the run
  string   row_name [$];

  // Commands that were acked and still wait for their response
  int      fl_eng [$];
  opcode_t fl_op  [$];
  dat_t    fl_dat [$];
  int      fl_row [$];
  int      fl_cyc [$];

  // Serial model, one LIFO per engine and a count of free nodes
  dat_t    stk [ENGS_N][$];
  int      free_n = PTR_N;

  // Engines that already won once while engine e kept waiting
  logic [ENGS_N-1:0] seen [ENGS_N];

  int      cyc       = 0;
  int      rsp_cnt   = 0;
  int      val_err   = 0;
  int      proto_err = 0;

  int      eng;
  opcode_t op;
  dat_t    dat;
  int      row;
  int      ack_cyc;
  status_t exp_status;
  dat_t    exp_dat;

  task automatic add_name(input string name);
    row_name.push_back(name);
  endtask

  task automatic compare(input string name, input string field,
                         input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: %s expected %0h, actual %0h", name, field, exp, act);
      val_err++;
    end
  endtask

  initial begin
    for (int e = 0; e < ENGS_N; e++) begin
      seen[e] = '0;
    end
  end

  always @(posedge clk) begin
    if (i_arst_n) begin
      cyc++;
      // Responses are handled before new acks so the oldest command matches
      if (i_rsp_vld) begin
        if (fl_eng.size() == 0) begin
          $display("A response for engine %0d arrived with no command in flight",
                   i_rsp_engid);
          proto_err++;
        end else begin
          eng     = fl_eng.pop_front();
          op      = fl_op.pop_front();
          dat     = fl_dat.pop_front();
          row     = fl_row.pop_front();
          ack_cyc = fl_cyc.pop_front();
          exp_status = OK;
          exp_dat    = '0;
          case (op)
            PUSH: begin
              if (free_n == 0) begin
                exp_status = FULL;
              end else begin
                free_n--;
                stk[eng].push_back(dat);
                exp_dat = dat;
              end
            end
            POP: begin
              if (stk[eng].size() == 0) begin
                exp_status = EMPTY;
              end else begin
                exp_dat = stk[eng].pop_back();
                free_n++;
              end
            end
            default: begin
              if (stk[eng].size() == 0) begin
                exp_status = EMPTY;
              end else begin
                exp_dat = stk[eng][$];
              end
            end
          endcase
          compare(row_name[row], "engid", 32'(eng), 32'(i_rsp_engid));
          compare(row_name[row], "opcode", 32'(op), 32'(i_rsp_opcode));
          compare(row_name[row], "status", 32'(exp_status), 32'(i_rsp_status));
          compare(row_name[row], "data", exp_dat, i_rsp_dat);
          // Every response is due exactly two cycles after its ack
          if (cyc - ack_cyc != 2) begin
            $display("Response in %s came %0d cycles after its ack instead of 2",
                     row_name[row], cyc - ack_cyc);
            proto_err++;
          end
          rsp_cnt++;
        end
      end
      for (int g = 0; g < ENGS_N; g++) begin
        if (i_cmd_ack[g]) begin
          fl_eng.push_back(g);
          fl_op.push_back(i_cmd_opcode[g]);
          fl_dat.push_back(i_cmd_dat[g]);
          fl_row.push_back(int'(i_cmd_row[g]));
          fl_cyc.push_back(cyc);
          // A waiting engine may see each other engine win at most once
          for (int e = 0; e < ENGS_N; e++) begin
            if (e != g && i_cmd_opcode[e] != NOP) begin
              if (seen[e][g]) begin
                $display("Engine %0d was granted twice while engine %0d kept waiting", g, e);
                proto_err++;
              end
              seen[e][g] = 1'b1;
            end
          end
          seen[g] = '0;
        end
      end
    end
  end

endmodule : stk_pipe_checker

// File: verif/tb_stk_pipe.sv
module tb_stk_pipe import cfg_pkg::*, stk_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int FIXED  = 0;
  localparam int RANDOM = 1;

  logic                       clk;
  logic                       i_arst_n;
  opcode_t [ENGS_N-1:0]       cmd_opcode;
  dat_t    [ENGS_N-1:0]       cmd_dat;
  logic    [ENGS_N-1:0][15:0] cmd_row;
  logic    [ENGS_N-1:0]       cmd_ack;
  logic                       rsp_vld;
  engid_t                     rsp_engid;
  opcode_t                    rsp_opcode;
  status_t                    rsp_status;
  dat_t                       rsp_dat;

  // Stimulus table with one entry per command
  string   row_name [$];
  int      row_eng  [$];
  opcode_t row_op   [$];
  dat_t    row_dat  [$];
  int      rows_n = 0;
  logic    built  = 1'b0;

  // Rows waiting to be presented by each engine
  int      pend [ENGS_N][$];

  logic [31:0] lcg_state = 32'd23;

  stk_pipe uut (
      .i_cmd_opcode (cmd_opcode)
    , .i_cmd_dat    (cmd_dat)
    , .o_cmd_ack    (cmd_ack)
    , .o_rsp_vld    (rsp_vld)
    , .o_rsp_engid  (rsp_engid)
    , .o_rsp_opcode (rsp_opcode)
    , .o_rsp_status (rsp_status)
    , .o_rsp_dat    (rsp_dat)
    , .clk          (clk)
    , .i_arst_n     (i_arst_n)
  );

  stk_pipe_checker u_chk (
      .clk          (clk)
    , .i_arst_n     (i_arst_n)
    , .i_cmd_opcode (cmd_opcode)
    , .i_cmd_dat    (cmd_dat)
    , .i_cmd_ack    (cmd_ack)
    , .i_cmd_row    (cmd_row)
    , .i_rsp_vld    (rsp_vld)
    , .i_rsp_engid  (rsp_engid)
    , .i_rsp_opcode (rsp_opcode)
    , .i_rsp_status (rsp_status)
    , .i_rsp_dat    (rsp_dat)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic add_row(input string name, input int eng, input opcode_t op,
                         input int mode, input dat_t dat);
    row_name.push_back(name);
    row_eng.push_back(eng);
    row_op.push_back(op);
    row_dat.push_back((mode == RANDOM) ? lcg_next() : dat);
    u_chk.add_name(name);
    rows_n++;
  endtask

  // Wait until the first n rows have all been answered
  task automatic wait_drain(input int n);
    while (u_chk.rsp_cnt < n) begin
      @(negedge clk);
    end
  endtask

  task automatic build_table();
    logic [31:0] r;
    add_row("lifo", 0, PUSH, FIXED, 32'hA1A1_0001);
    add_row("lifo", 0, PUSH, FIXED, 32'hB2B2_0002);
    add_row("lifo", 0, PEEK, FIXED, '0);
    add_row("lifo", 0, POP,  FIXED, '0);
    add_row("lifo", 0, POP,  FIXED, '0);
    add_row("lifo", 0, POP,  FIXED, '0);
    add_row("empty", 1, PEEK, FIXED, '0);
    add_row("empty", 1, POP,  FIXED, '0);
    // Eight pushes use every node and the third push of engine 0 comes last
    for (int k = 0; k < 2; k++) begin
      for (int e = 0; e < ENGS_N; e++) begin
        add_row("full", e, PUSH, RANDOM, '0);
      end
    end
    add_row("full", 0, PUSH, RANDOM, '0);
    // The PUSH only finds a node through the release bypass
    add_row("bypass", 3, POP,  FIXED, '0);
    add_row("bypass", 3, PUSH, FIXED, 32'h5A5A_5A5A);
    for (int e = 0; e < ENGS_N; e++) begin
      add_row("drain", e, POP, FIXED, '0);
      add_row("drain", e, POP, FIXED, '0);
    end
    for (int k = 0; k < 2; k++) begin
      for (int e = 0; e < ENGS_N; e++) begin
        add_row("interleave", e, PUSH, FIXED, dat_t'((e << 8) | k));
      end
    end
    for (int k = 0; k < 2; k++) begin
      for (int e = 0; e < ENGS_N; e++) begin
        add_row("interleave", e, POP, FIXED, '0);
      end
    end
    for (int k = 0; k < 2; k++) begin
      for (int e = 0; e < ENGS_N; e++) begin
        add_row("round_robin", e, PEEK, FIXED, '0);
      end
    end
    // Pushes are weighted double so the free list gets exercised
    for (int k = 0; k < 200; k++) begin
      r = lcg_next();
      add_row("random", int'(r[17:16]),
              (r[29:28] == 2'd2) ? POP : (r[29:28] == 2'd3) ? PEEK : PUSH, RANDOM, '0);
    end
    built = 1'b1;
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Each engine shows the head of its queue until it is acked
  always @(negedge clk) begin
    for (int e = 0; e < ENGS_N; e++) begin
      if (pend[e].size() > 0) begin
        cmd_opcode[e] = row_op[pend[e][0]];
        cmd_dat[e]    = row_dat[pend[e][0]];
        cmd_row[e]    = 16'(pend[e][0]);
      end else begin
        cmd_opcode[e] = NOP;
        cmd_dat[e]    = '0;
        cmd_row[e]    = '0;
      end
    end
  end

  always @(posedge clk) begin
    if (i_arst_n) begin
      for (int e = 0; e < ENGS_N; e++) begin
        if (cmd_ack[e] && pend[e].size() > 0) begin
          void'(pend[e].pop_front());
        end
      end
    end
  end

  initial begin
    wait (built);
    repeat (rows_n * (ENGS_N + 4) + 20) @(posedge clk);
    $display("Timeout: only %0d of %0d responses arrived", u_chk.rsp_cnt, rows_n);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    i_arst_n = 1'b0;
    for (int e = 0; e < ENGS_N; e++) begin
      cmd_opcode[e] = NOP;
      cmd_dat[e]    = '0;
      cmd_row[e]    = '0;
    end
    build_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    i_arst_n = 1'b1;
    // A new test starts only after the previous one has fully drained
    for (int r = 0; r < rows_n; r++) begin
      if (r > 0 && row_name[r] != row_name[r-1]) begin
        wait_drain(r);
      end
      pend[row_eng[r]].push_back(r);
    end
    wait_drain(rows_n);
    repeat (3) @(negedge clk);
    $display("Responses %0d of %0d, value errors %0d, protocol errors %0d, assert errors %0d",
             u_chk.rsp_cnt, rows_n, u_chk.val_err, u_chk.proto_err,
             uut.u_stk_pipe_asserts.fail_n);
    if (u_chk.val_err == 0 && u_chk.proto_err == 0 &&
        uut.u_stk_pipe_asserts.fail_n == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_stk_pipe
